// ==== logic/rv_alu_pkg.sv ====
/* shared definitions of the execute subsystem: ALU control enums, RISC-V major
   opcodes and the word map of the Wishbone slave port */

package rv_alu_pkg;

  //////////////////////////////////////////////////////////////////////
  // ALU control
  //////////////////////////////////////////////////////////////////////

  // operand source select
  typedef enum logic [1:0] {
    AI_R1_R2 = 2'd0,  // rs1, rs2
    AI_R1_IM = 2'd1,  // rs1, immediate
    AI_PC_IM = 2'd2   // pc, immediate (auipc)
  } ai_t;

  // operation, {funct7[5], funct3}
  // msb (f7_5) also inverts operand 2 in the adder
  typedef enum logic [3:0] {
    AO_ADD  = 4'b0000,
    AO_SUB  = 4'b1000,
    AO_SLL  = 4'b0001,
    AO_SLT  = 4'b0010,
    AO_SLTU = 4'b0011,
    AO_XOR  = 4'b0100,
    AO_SRL  = 4'b0101,
    AO_SRA  = 4'b1101,
    AO_OR   = 4'b0110,
    AO_AND  = 4'b0111
  } ao_t;

  // operand extension and result width
  typedef enum logic [1:0] {
    R_SX = 2'd0,  // signed, full width
    R_UX = 2'd1,  // unsigned, full width
    R_SW = 2'd2,  // signed 32-bit word
    R_UW = 2'd3   // unsigned 32-bit word
  } rt_t;

  //////////////////////////////////////////////////////////////////////
  // major opcodes, instr[6:0]
  //////////////////////////////////////////////////////////////////////

  typedef enum logic [6:0] {
    OPC_OP        = 7'b0110011,
    OPC_OP_IMM    = 7'b0010011,
    OPC_OP_32     = 7'b0111011,  // rv64 only
    OPC_OP_IMM_32 = 7'b0011011,  // rv64 only
    OPC_LUI       = 7'b0110111,
    OPC_AUIPC     = 7'b0010111
  } opc_t;

  // wishbone word addresses, xN lives at REG_X0 + N
  localparam logic [5:0] REG_X0     = 6'd0;
  localparam logic [5:0] REG_PC     = 6'd32;
  localparam logic [5:0] REG_INSTR  = 6'd33;  // write starts execution
  localparam logic [5:0] REG_STATUS = 6'd34;  // {overflow, illegal}

endpackage

// ==== logic/rv_decode.sv ====
/* instruction decoder, maps one 32-bit word onto ALU control, register
   indexes and a sign-extended immediate; flags anything it cannot run */

`timescale 1ns/1ps

module rv_decode #(
  parameter int unsigned XLEN = 32
) (
  input  logic [31:0]          instr,
  output logic [4:0]           rs1_idx,
  output logic [4:0]           rs2_idx,
  output logic [4:0]           rd_idx,
  output rv_alu_pkg::ai_t      ai,
  output rv_alu_pkg::ao_t      ao,
  output rv_alu_pkg::rt_t      rt,
  output logic [XLEN-1:0]      imm,
  output logic                 illegal
);

  rv_alu_pkg::opc_t opc;
  logic [6:0]       f7;
  logic [2:0]       f3;
  logic [XLEN-1:0]  imm_i;     // I-type
  logic [XLEN-1:0]  imm_u;     // U-type
  logic             f7_ok;     // funct7 zero, or 0x20 on sub/sra
  logic [5:0]       sh_hi;     // shift-imm bits that must be zero

  assign opc = rv_alu_pkg::opc_t'(instr[6:0]);
  assign f7  = instr[31:25];
  assign f3  = instr[14:12];

  assign imm_i = XLEN'($signed(instr[31:20]));
  assign imm_u = XLEN'($signed({instr[31:12], 12'h000}));

  assign f7_ok = (f7 == 7'b0000000) ||
                 (f7 == 7'b0100000 && (f3 == 3'b000 || f3 == 3'b101));

  // instr[25] is shamt[5] on rv64, reserved on rv32; bit 30 checked apart
  assign sh_hi = {instr[31], instr[29:26], (XLEN == 32) && instr[25]};

  //////////////////////////////////////////////////////////////////////
  // decode
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    rs1_idx = instr[19:15];
    rs2_idx = instr[24:20];
    rd_idx  = instr[11:7];
    ai      = rv_alu_pkg::AI_R1_R2;
    ao      = rv_alu_pkg::AO_ADD;
    rt      = rv_alu_pkg::R_SX;
    imm     = imm_i;
    illegal = 1'b0;
    case (opc)
      rv_alu_pkg::OPC_OP: begin
        ao      = rv_alu_pkg::ao_t'({f7[5], f3});
        rt      = (f3 == 3'b011) ? rv_alu_pkg::R_UX : rv_alu_pkg::R_SX;  // sltu
        illegal = !f7_ok;
      end
      rv_alu_pkg::OPC_OP_IMM: begin
        ai = rv_alu_pkg::AI_R1_IM;
        rt = (f3 == 3'b011) ? rv_alu_pkg::R_UX : rv_alu_pkg::R_SX;  // sltiu
        case (f3)
          3'b001: begin  // slli
            ao      = rv_alu_pkg::AO_SLL;
            illegal = (sh_hi != 6'd0) || instr[30];
          end
          3'b101: begin  // srli / srai, bit 30 picks
            ao      = rv_alu_pkg::ao_t'({instr[30], f3});
            illegal = (sh_hi != 6'd0);
          end
          default: ao = rv_alu_pkg::ao_t'({1'b0, f3});  // f7_5 ignored here
        endcase
      end
      rv_alu_pkg::OPC_OP_32: begin
        ao      = rv_alu_pkg::ao_t'({f7[5], f3});
        rt      = rv_alu_pkg::R_SW;
        illegal = (XLEN == 32) || !f7_ok ||
                  !(f3 == 3'b000 || f3 == 3'b001 || f3 == 3'b101);
      end
      rv_alu_pkg::OPC_OP_IMM_32: begin
        ai = rv_alu_pkg::AI_R1_IM;
        rt = rv_alu_pkg::R_SW;
        case (f3)
          3'b000:  illegal = (XLEN == 32);                              // addiw
          3'b001: begin                                                 // slliw
            ao      = rv_alu_pkg::AO_SLL;
            illegal = (XLEN == 32) || (f7 != 7'b0000000);
          end
          3'b101: begin                                                 // srliw/sraiw
            ao      = rv_alu_pkg::ao_t'({f7[5], f3});
            illegal = (XLEN == 32) || !f7_ok;
          end
          default: illegal = 1'b1;
        endcase
      end
      rv_alu_pkg::OPC_LUI: begin
        ai      = rv_alu_pkg::AI_R1_IM;
        rs1_idx = 5'd0;  // x0 + imm
        imm     = imm_u;
      end
      rv_alu_pkg::OPC_AUIPC: begin
        ai  = rv_alu_pkg::AI_PC_IM;
        imm = imm_u;
      end
      default: illegal = 1'b1;  // loads, stores, branches, ...
    endcase
  end

endmodule

// ==== logic/rv_alu.sv ====
/* integer ALU: operand select, one extended adder shared by add/sub/compare,
   barrel shifts, bitwise ops, and sign extension of 32-bit word results */

`timescale 1ns/1ps

module rv_alu #(
  parameter int unsigned XLEN = 32
) (
  input  logic              clk,  // unused, room for pipeline stages
  input  logic              rst,  // unused as well
  input  rv_alu_pkg::ai_t   ai,
  input  rv_alu_pkg::ao_t   ao,
  input  rv_alu_pkg::rt_t   rt,
  input  logic [XLEN-1:0]   imm,
  input  logic [XLEN-1:0]   pc,
  input  logic [XLEN-1:0]   rs1,
  input  logic [XLEN-1:0]   rs2,
  output logic [XLEN-1:0]   rd,
  output logic [XLEN:0]     sum   // msb is carry / sign of compare
);

  localparam int unsigned SW = $clog2(XLEN);

  logic [XLEN-1:0] in1, in2;  // after operand select
  logic [XLEN:0]   op1, op2;  // extended by one bit
  logic            inv;       // subtract
  logic            word;      // 32-bit result forms
  logic [SW-1:0]   sa;        // shift amount
  logic [XLEN-1:0] sh_u;      // logical shift source
  logic [XLEN-1:0] sh_s;      // arithmetic shift source
  logic [XLEN-1:0] val;

  always_comb begin
    case (ai)
      rv_alu_pkg::AI_R1_IM: begin
        in1 = rs1;
        in2 = imm;
      end
      rv_alu_pkg::AI_PC_IM: begin
        in1 = pc;
        in2 = imm;
      end
      default: begin
        in1 = rs1;
        in2 = rs2;
      end
    endcase
  end

  assign word = (rt == rv_alu_pkg::R_SW) || (rt == rv_alu_pkg::R_UW);

  //////////////////////////////////////////////////////////////////////
  // adder
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    case (rt)
      rv_alu_pkg::R_UX: begin
        op1 = (XLEN+1)'(in1);  // zero extend
        op2 = (XLEN+1)'(in2);
      end
      rv_alu_pkg::R_SW: begin
        op1 = (XLEN+1)'($signed(in1[31:0]));
        op2 = (XLEN+1)'($signed(in2[31:0]));
      end
      rv_alu_pkg::R_UW: begin
        op1 = (XLEN+1)'(in1[31:0]);
        op2 = (XLEN+1)'(in2[31:0]);
      end
      default: begin     // R_SX
        op1 = (XLEN+1)'($signed(in1));
        op2 = (XLEN+1)'($signed(in2));
      end
    endcase
  end

  // compares are a subtract, sign taken from the extra bit
  assign inv = ao[3] || (ao == rv_alu_pkg::AO_SLT) || (ao == rv_alu_pkg::AO_SLTU);

  assign sum = op1 + (inv ? ~op2 : op2) + (XLEN+1)'(inv);

  //////////////////////////////////////////////////////////////////////
  // shifter
  //////////////////////////////////////////////////////////////////////

  assign sa   = word ? SW'(in2[4:0]) : in2[SW-1:0];  // words use 5 bits
  assign sh_u = word ? XLEN'(in1[31:0]) : in1;
  assign sh_s = word ? XLEN'($signed(in1[31:0])) : in1;

  //////////////////////////////////////////////////////////////////////
  // result
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    case (ao)
      rv_alu_pkg::AO_ADD,
      rv_alu_pkg::AO_SUB:  val = sum[XLEN-1:0];
      rv_alu_pkg::AO_SLT,
      rv_alu_pkg::AO_SLTU: val = XLEN'(sum[XLEN]);  // borrow means less
      rv_alu_pkg::AO_AND:  val = in1 & in2;
      rv_alu_pkg::AO_OR:   val = in1 | in2;
      rv_alu_pkg::AO_XOR:  val = in1 ^ in2;
      rv_alu_pkg::AO_SLL:  val = in1 << sa;
      rv_alu_pkg::AO_SRL:  val = sh_u >> sa;
      rv_alu_pkg::AO_SRA:  val = XLEN'($signed(sh_s) >>> sa);
      default:             val = '0;
    endcase
  end

  assign rd = word ? XLEN'($signed(val[31:0])) : val;  // *w forms sign extend

endmodule

// ==== logic/rv_regfile.sv ====
/* integer register file, 32 entries, two asynchronous read ports and one
   synchronous write port; x0 always reads as zero */

`timescale 1ns/1ps

module rv_regfile #(
  parameter int unsigned XLEN = 32
) (
  input  logic            clk,
  input  logic [4:0]      ra_idx,
  input  logic [4:0]      rb_idx,
  input  logic            we,
  input  logic [4:0]      w_idx,
  input  logic [XLEN-1:0] w_dat,
  output logic [XLEN-1:0] ra_dat,
  output logic [XLEN-1:0] rb_dat
);

  logic [XLEN-1:0] mem [32];  // plain flops, cleared by the controller

  always_ff @(posedge clk) begin
    if (we && (w_idx != 5'd0)) begin  // x0 is hardwired
      mem[w_idx] <= w_dat;
    end
  end

  // read ports
  assign ra_dat = (ra_idx == 5'd0) ? '0 : mem[ra_idx];
  assign rb_dat = (rb_idx == 5'd0) ? '0 : mem[rb_idx];

endmodule

// ==== logic/rv_exec_ctrl.sv ====
/* Wishbone classic slave and sequencer: host access to registers, PC and
   status, register file clear after reset, one instruction at a time */

`timescale 1ns/1ps

module rv_exec_ctrl #(
  parameter int unsigned XLEN = 32
) (
  input  logic            clk,
  input  logic            rst,
  // wishbone
  input  logic            wb_cyc,
  input  logic            wb_stb,
  input  logic            wb_we,
  input  logic [5:0]      wb_adr,
  input  logic [XLEN-1:0] wb_dat_w,
  output logic [XLEN-1:0] wb_dat_r,
  output logic            wb_ack,
  // decoder
  output logic [31:0]     instr,
  input  logic [4:0]      rs1_idx,
  input  logic [4:0]      rd_idx,
  input  logic            illegal,
  // register file
  output logic [4:0]      ra_idx,
  input  logic [XLEN-1:0] ra_dat,
  output logic            rf_we,
  output logic [4:0]      rf_w_idx,
  output logic [XLEN-1:0] rf_w_dat,
  // alu
  input  logic [XLEN-1:0] alu_rd,
  input  logic [XLEN:0]   alu_sum,
  output logic [XLEN-1:0] pc
);

  typedef enum logic [1:0] {
    ST_CLEAR,      // zeroing the register file
    ST_IDLE,
    ST_ACK,        // ack pulse out
    ST_WRITEBACK   // decode/alu settled, commit on next edge
  } state_t;

  state_t     state;
  logic [4:0] clr_idx;
  logic [1:0] status;  // [1] overflow, [0] sticky illegal
  logic       req;     // new strobe seen
  logic       is_reg;  // address hits x0..x31

  assign req    = (state == ST_IDLE) && wb_cyc && wb_stb;
  assign is_reg = (wb_adr[5] == 1'b0);

  //////////////////////////////////////////////////////////////////////
  // sequencer
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      state   <= ST_CLEAR;
      clr_idx <= 5'd0;
      wb_ack  <= 1'b0;
      pc      <= '0;
      status  <= 2'b00;
    end else begin
      wb_ack <= 1'b0;
      case (state)
        ST_CLEAR: begin
          clr_idx <= clr_idx + 5'd1;
          if (clr_idx == 5'd31) state <= ST_IDLE;
        end
        ST_IDLE: begin
          if (req) begin
            wb_ack <= 1'b1;     // every access but instr acks next cycle
            state  <= ST_ACK;
            if (wb_we) begin
              case (wb_adr)
                rv_alu_pkg::REG_PC:     pc <= wb_dat_w;
                rv_alu_pkg::REG_STATUS: status[0] <= 1'b0;  // clear illegal
                rv_alu_pkg::REG_INSTR: begin
                  wb_ack <= 1'b0;  // held back one cycle
                  state  <= ST_WRITEBACK;
                end
                default: ;          // registers via rf port, rest ignored
              endcase
            end
          end
        end
        ST_WRITEBACK: begin
          wb_ack <= 1'b1;
          state  <= ST_ACK;
          if (illegal) begin
            status[0] <= 1'b1;
          end else begin
            pc        <= pc + XLEN'(4);
            status[1] <= alu_sum[XLEN];
          end
        end
        default: state <= ST_IDLE;  // ST_ACK, host drops stb now
      endcase
    end
  end

  // instruction word, payload only
  always_ff @(posedge clk) begin
    if (req && wb_we && (wb_adr == rv_alu_pkg::REG_INSTR)) begin
      instr <= wb_dat_w[31:0];
    end
  end

  //////////////////////////////////////////////////////////////////////
  // register file ports
  //////////////////////////////////////////////////////////////////////

  // port A belongs to the host unless an instruction is in flight
  assign ra_idx = (state == ST_WRITEBACK) ? rs1_idx : wb_adr[4:0];

  // one write port, clear / host / write-back never overlap
  always_comb begin
    rf_we    = 1'b0;
    rf_w_idx = wb_adr[4:0];
    rf_w_dat = wb_dat_w;
    case (state)
      ST_CLEAR: begin
        rf_we    = 1'b1;
        rf_w_idx = clr_idx;
        rf_w_dat = '0;
      end
      ST_IDLE:  rf_we = req && wb_we && is_reg;
      ST_WRITEBACK: begin
        rf_we    = !illegal;  // bad opcode writes nothing
        rf_w_idx = rd_idx;
        rf_w_dat = alu_rd;
      end
      default: ;
    endcase
  end

  // read data, valid while the host holds the address
  always_comb begin
    if (is_reg) begin
      wb_dat_r = ra_dat;
    end else begin
      case (wb_adr)
        rv_alu_pkg::REG_PC:     wb_dat_r = pc;
        rv_alu_pkg::REG_INSTR:  wb_dat_r = XLEN'(instr);
        rv_alu_pkg::REG_STATUS: wb_dat_r = XLEN'(status);
        default:                wb_dat_r = '0;  // unmapped
      endcase
    end
  end

endmodule

// ==== logic/rv_exec_top.sv ====
/* top of the execute subsystem: Wishbone slave port in, controller, decoder,
   register file and ALU wired together; XLEN chosen here */

`timescale 1ns/1ps

module rv_exec_top #(
  parameter int unsigned XLEN = 32
) (
  input  logic            clk,
  input  logic            rst,
  input  logic            wb_cyc,
  input  logic            wb_stb,
  input  logic            wb_we,
  input  logic [5:0]      wb_adr,
  input  logic [XLEN-1:0] wb_dat_w,
  output logic [XLEN-1:0] wb_dat_r,
  output logic            wb_ack
);

  logic [31:0]     instr;
  logic [4:0]      rs1_idx, rs2_idx, rd_idx;
  logic            illegal;
  rv_alu_pkg::ai_t ai;
  rv_alu_pkg::ao_t ao;
  rv_alu_pkg::rt_t rt;
  logic [XLEN-1:0] imm, pc;
  logic [4:0]      ra_idx;
  logic [XLEN-1:0] ra_dat, rb_dat;
  logic            rf_we;
  logic [4:0]      rf_w_idx;
  logic [XLEN-1:0] rf_w_dat;
  logic [XLEN-1:0] alu_rd;
  logic [XLEN:0]   alu_sum;

  rv_exec_ctrl #(.XLEN(XLEN)) rv_exec_ctrl_inst (
    .clk, .rst,
    .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_w, .wb_dat_r, .wb_ack,
    .instr, .rs1_idx, .rd_idx, .illegal,
    .ra_idx, .ra_dat, .rf_we, .rf_w_idx, .rf_w_dat,
    .alu_rd, .alu_sum, .pc
  );

  rv_decode #(.XLEN(XLEN)) rv_decode_inst (
    .instr, .rs1_idx, .rs2_idx, .rd_idx, .ai, .ao, .rt, .imm, .illegal
  );

  rv_regfile #(.XLEN(XLEN)) rv_regfile_inst (
    .clk, .ra_idx, .rb_idx(rs2_idx), .we(rf_we), .w_idx(rf_w_idx),
    .w_dat(rf_w_dat), .ra_dat, .rb_dat
  );

  rv_alu #(.XLEN(XLEN)) rv_alu_inst (
    .clk, .rst, .ai, .ao, .rt, .imm, .pc,
    .rs1(ra_dat), .rs2(rb_dat), .rd(alu_rd), .sum(alu_sum)
  );

endmodule

// ==== dv/rv_exec_tb.sv ====
/* testbench of the execute subsystem: drives the Wishbone port, keeps a model of the
   registers and PC, and checks every result against a reference function */

`timescale 1ns/1ps

module rv_exec_tb;

  localparam int XLEN        = 32;
  localparam int ACK_TIMEOUT = 20;   // cycles per bus access
  localparam int N_RR        = 150;  // reg-reg instructions
  localparam int N_RI        = 150;  // reg-imm instructions
  localparam int N_UP        = 40;   // lui / auipc

  logic            clk;
  logic            rst;
  logic            wb_cyc;
  logic            wb_stb;
  logic            wb_we;
  logic [5:0]      wb_adr;
  logic [XLEN-1:0] wb_dat_w;
  logic [XLEN-1:0] wb_dat_r;
  logic            wb_ack;

  logic [31:0] lfsr = 32'he31c;
  logic [31:0] regs [32];  // x0 never written, stays zero
  logic [31:0] pc_model;
  logic        ill_model;  // sticky illegal flag
  int          errors   = 0;
  int          timeouts = 0;

  rv_exec_top #(.XLEN(XLEN)) rv_exec_top_inst (
    .clk, .rst, .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_w, .wb_dat_r, .wb_ack
  );

  always #50 clk = ~clk;  // 100 ns period

  //////////////////////////////////////////////////////////////////////
  // random numbers
  //////////////////////////////////////////////////////////////////////

  // fibonacci lfsr x^32+x^22+x^2+x+1, one step per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    logic        fb;
    v = '0;
    for (int i = 0; i < n; i++) begin
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      v    = {v[30:0], fb};
    end
    return v;
  endfunction

  function automatic logic [4:0] rand5();
    logic [31:0] t;
    t = rand_bits(5);
    return t[4:0];
  endfunction

  // operand with a bias toward the edge values
  function automatic logic [31:0] rand_operand();
    logic [31:0] sel;
    sel = rand_bits(3);
    case (sel[2:0])
      3'd0:    return 32'h0000_0000;
      3'd1:    return 32'h0000_0001;
      3'd2:    return 32'h8000_0000;  // most negative
      3'd3:    return 32'hffff_ffff;
      3'd4:    return 32'h7fff_ffff;
      default: return rand_bits(32);
    endcase
  endfunction

  function automatic logic [11:0] rand_imm();
    logic [31:0] sel;
    logic [31:0] t;
    sel = rand_bits(3);
    t   = rand_bits(12);
    case (sel[2:0])
      3'd0:    return 12'h000;
      3'd1:    return 12'h001;
      3'd2:    return 12'h800;
      3'd3:    return 12'hfff;  // -1
      3'd4:    return 12'h7ff;
      default: return t[11:0];
    endcase
  endfunction

  //////////////////////////////////////////////////////////////////////
  // reference model
  //////////////////////////////////////////////////////////////////////

  function automatic void exec_ref(input logic [31:0] ins, input logic [31:0] pc_in,
                                   output logic [31:0] rd_val, output logic [31:0] pc_out,
                                   output logic ill, output logic ovf, output logic adder);
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic [3:0]  op;   // {funct7[5], funct3}
    logic [31:0] a;
    logic [31:0] b;
    logic [32:0] ea;
    logic [32:0] eb;
    logic [32:0] s;
    logic        uns;
    logic        sub_op;
    f3     = ins[14:12];
    f7     = ins[31:25];
    a      = regs[ins[19:15]];
    b      = regs[ins[24:20]];
    op     = 4'b0000;
    ill    = 1'b0;
    rd_val = '0;
    case (ins[6:0])
      7'h33: begin  // OP
        op  = {f7[5], f3};
        ill = !((f7 == 7'h00) || (f7 == 7'h20 && (f3 == 3'b000 || f3 == 3'b101)));
      end
      7'h13: begin  // OP-IMM
        b  = {{20{ins[31]}}, ins[31:20]};
        op = (f3 == 3'b101) ? {ins[30], f3} : {1'b0, f3};
        if (f3 == 3'b001) ill = (f7 != 7'h00);
        if (f3 == 3'b101) ill = (ins[31] || ins[29:25] != 5'd0);
      end
      7'h37: begin  // lui, x0 + imm
        a = '0;
        b = {ins[31:12], 12'h000};
      end
      7'h17: begin  // auipc
        a = pc_in;
        b = {ins[31:12], 12'h000};
      end
      default: ill = 1'b1;  // word forms too, xlen 32
    endcase
    uns    = (op[2:0] == 3'b011);                      // sltu / sltiu
    sub_op = (op == 4'b1000) || (op[2:1] == 2'b01);   // sub, slt, sltu
    ea     = uns ? {1'b0, a} : {a[31], a};
    eb     = uns ? {1'b0, b} : {b[31], b};
    s      = sub_op ? ea + ~eb + 33'd1 : ea + eb;
    adder  = 1'b0;
    case (op)
      4'b0000, 4'b1000: begin
        rd_val = (op == 4'b1000) ? a - b : a + b;
        adder  = 1'b1;
      end
      4'b0010, 4'b0011: begin
        rd_val = uns ? {31'b0, a < b} : {31'b0, $signed(a) < $signed(b)};  // plain compare
        adder  = 1'b1;
      end
      4'b0001: rd_val = a << b[4:0];
      4'b0101: rd_val = a >> b[4:0];
      4'b1101: rd_val = $signed(a) >>> b[4:0];
      4'b0100: rd_val = a ^ b;
      4'b0110: rd_val = a | b;
      4'b0111: rd_val = a & b;
      default: rd_val = '0;
    endcase
    ovf    = s[32];
    pc_out = ill ? pc_in : pc_in + 32'd4;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // checks and bus tasks
  //////////////////////////////////////////////////////////////////////

  task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp) else begin
      $display("** Error %s: expected %h, actual %h", name, exp, act);
      errors++;
    end
  endtask

  // one classic cycle, called and left 1 ns after a rising edge
  task automatic wb_cycle(input logic we, input logic [5:0] adr, input logic [31:0] dat,
                          output logic [31:0] rdat);
    int   n;
    logic got;
    n        = 0;
    got      = 1'b0;
    rdat     = 'x;
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = we;
    wb_adr   = adr;
    wb_dat_w = dat;
    while (!got && n < ACK_TIMEOUT) begin
      @(posedge clk);
      #1;
      if (wb_ack) begin
        got  = 1'b1;
        rdat = wb_dat_r;  // valid in the ack cycle
      end
      n++;
    end
    if (!got) begin
      $display("no ack from the DUT within %0d cycles, address %0d", ACK_TIMEOUT, adr);
      timeouts++;
    end
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
  endtask

  task automatic wb_write(input logic [5:0] adr, input logic [31:0] dat);
    logic [31:0] unused;
    wb_cycle(1'b1, adr, dat, unused);
  endtask

  task automatic wb_read(input logic [5:0] adr, output logic [31:0] dat);
    wb_cycle(1'b0, adr, '0, dat);
  endtask

  task automatic host_write_reg(input logic [4:0] idx, input logic [31:0] v);
    wb_write({1'b0, idx}, v);
    if (idx != 5'd0) regs[idx] = v;  // x0 discards
  endtask

  // r-type k: add sub sll slt sltu xor srl sra or and
  task automatic build_rr(input int k, input logic [4:0] rd, input logic [4:0] rs1,
                          input logic [4:0] rs2, output string name, output logic [31:0] ins);
    logic [2:0] f3;
    logic [6:0] f7;
    f7 = 7'h00;
    case (k)
      0: begin name = "add";  f3 = 3'b000; end
      1: begin name = "sub";  f3 = 3'b000; f7 = 7'h20; end
      2: begin name = "sll";  f3 = 3'b001; end
      3: begin name = "slt";  f3 = 3'b010; end
      4: begin name = "sltu"; f3 = 3'b011; end
      5: begin name = "xor";  f3 = 3'b100; end
      6: begin name = "srl";  f3 = 3'b101; end
      7: begin name = "sra";  f3 = 3'b101; f7 = 7'h20; end
      8: begin name = "or";   f3 = 3'b110; end
      default: begin name = "and"; f3 = 3'b111; end
    endcase
    ins = {f7, rs2, rs1, f3, rd, 7'h33};
  endtask

  task automatic build_ri(input int k, input logic [4:0] rd, input logic [4:0] rs1,
                          output string name, output logic [31:0] ins);
    logic [2:0]  f3;
    logic [11:0] imm;
    imm = rand_imm();
    case (k)
      0: begin name = "addi";  f3 = 3'b000; end
      1: begin name = "slti";  f3 = 3'b010; end
      2: begin name = "sltiu"; f3 = 3'b011; end
      3: begin name = "xori";  f3 = 3'b100; end
      4: begin name = "ori";   f3 = 3'b110; end
      5: begin name = "andi";  f3 = 3'b111; end
      6: begin name = "slli";  f3 = 3'b001; imm = {7'h00, rand5()}; end
      7: begin name = "srli";  f3 = 3'b101; imm = {7'h00, rand5()}; end
      default: begin name = "srai"; f3 = 3'b101; imm = {7'h20, rand5()}; end
    endcase
    ins = {imm, rs1, f3, rd, 7'h13};
  endtask

  // one instruction, then rd, pc and status read back against the model
  task automatic run_instr(input string name, input logic [31:0] ins);
    logic [31:0] exp_rd;
    logic [31:0] exp_pc;
    logic [31:0] act;
    logic        exp_ill;
    logic        exp_ovf;
    logic        is_add;
    logic [4:0]  rd;
    exec_ref(ins, pc_model, exp_rd, exp_pc, exp_ill, exp_ovf, is_add);
    wb_write(rv_alu_pkg::REG_INSTR, ins);
    rd = ins[11:7];
    if (exp_ill) begin
      ill_model = 1'b1;
    end else begin
      if (rd != 5'd0) regs[rd] = exp_rd;
      pc_model = exp_pc;
    end
    wb_read({1'b0, rd}, act);  // right after the ack, no gap
    check_val({name, " rd"}, regs[rd], act);
    wb_read(rv_alu_pkg::REG_PC, act);
    check_val({name, " pc"}, pc_model, act);
    wb_read(rv_alu_pkg::REG_STATUS, act);
    check_val({name, " illegal"}, {31'b0, ill_model}, {31'b0, act[0]});
    if (is_add && !exp_ill) check_val({name, " overflow"}, {31'b0, exp_ovf}, {31'b0, act[1]});
  endtask

  //////////////////////////////////////////////////////////////////////
  // stimulus
  //////////////////////////////////////////////////////////////////////

  initial begin
    logic [31:0] act;
    logic [31:0] up;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [4:0]  rd;
    logic [6:0]  opc;
    string       name;
    logic [31:0] ins;
    int          k;
    clk       = 1'b0;
    rst       = 1'b1;
    wb_cyc    = 1'b0;
    wb_stb    = 1'b0;
    wb_we     = 1'b0;
    wb_adr    = '0;
    wb_dat_w  = '0;
    pc_model  = '0;
    ill_model = 1'b0;
    for (int i = 0; i < 32; i++) regs[i] = '0;
    repeat (4) @(posedge clk);
    #1 rst = 1'b0;
    repeat (34) @(posedge clk);  // register file clear, 32 cycles
    #1;

    // reset values
    for (int i = 0; i < 32; i++) begin
      wb_read(6'(i), act);
      check_val("reset reg", 32'h0, act);
    end
    wb_read(rv_alu_pkg::REG_PC, act);
    check_val("reset pc", 32'h0, act);
    wb_read(rv_alu_pkg::REG_STATUS, act);
    check_val("reset status", 32'h0, act);

    // host write / read back, x0 included
    for (int i = 0; i < 32; i++) host_write_reg(5'(i), rand_operand());
    for (int i = 0; i < 32; i++) begin
      wb_read(6'(i), act);
      check_val("host rw", regs[i], act);
    end

    for (int n = 0; n < N_RR; n++) begin
      rs1 = rand5();
      rs2 = rand5();
      rd  = rand5();
      host_write_reg(rs1, rand_operand());
      host_write_reg(rs2, rand_operand());
      k = rand_bits(4) % 10;
      build_rr(k, rd, rs1, rs2, name, ins);
      run_instr(name, ins);
    end

    for (int n = 0; n < N_RI; n++) begin
      rs1 = rand5();
      rd  = rand5();
      host_write_reg(rs1, rand_operand());
      k = rand_bits(4) % 9;
      build_ri(k, rd, rs1, name, ins);
      run_instr(name, ins);
    end

    // upper immediates after a host-written pc
    for (int n = 0; n < N_UP; n++) begin
      pc_model = rand_bits(32);
      wb_write(rv_alu_pkg::REG_PC, pc_model);
      up   = rand_bits(20);
      rd   = rand5();
      opc  = (n % 2 == 0) ? 7'h37 : 7'h17;
      name = (n % 2 == 0) ? "lui" : "auipc";
      ins  = {up[19:0], rd, opc};
      run_instr(name, ins);
    end

    // addw on rv32, a load opcode, slli with a reserved funct7 bit
    host_write_reg(5'd5, rand_operand());
    run_instr("addw", {7'h00, 5'd7, 5'd6, 3'b000, 5'd5, 7'h3b});
    run_instr("load", {12'h004, 5'd6, 3'b010, 5'd5, 7'h03});
    run_instr("slli bad", {7'h02, 5'd3, 5'd6, 3'b001, 5'd5, 7'h13});
    wb_write(rv_alu_pkg::REG_STATUS, 32'h0);  // clears sticky illegal
    ill_model = 1'b0;
    wb_read(rv_alu_pkg::REG_STATUS, act);
    check_val("status clear", 32'h0, {31'b0, act[0]});

    $display("errors: %0d, timeouts: %0d", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// ==== verilog.f ====
logic/rv_alu_pkg.sv
logic/rv_decode.sv
logic/rv_alu.sv
logic/rv_regfile.sv
logic/rv_exec_ctrl.sv
logic/rv_exec_top.sv
dv/rv_exec_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the execute subsystem testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module rv_exec_tb --Mdir obj_dir -o rv_exec_sim -f verilog.f
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

./obj_dir/rv_exec_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulator returned status $status"
  exit 1
fi

if grep -qx "Simulation passed" sim.log; then
  exit 0
else
  exit 1
fi
